// File: common/arcade_pkg.sv
// shared constants and types for the arcade control layer
// bridge map, field widths, key bitmap positions, thresholds and timing
// imported by every design module that needs one of them

package arcade_pkg;

    //////////////////////////////////////////////////////////////////////
    // bridge map
    //////////////////////////////////////////////////////////////////////
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // exact-match register addresses
    localparam logic [ADDR_W-1:0] ADDR_LIVES       = 32'h2000_0000;
    localparam logic [ADDR_W-1:0] ADDR_DIFFICULTY  = 32'h3000_0000;
    localparam logic [ADDR_W-1:0] ADDR_BONUS       = 32'h4000_0000;
    localparam logic [ADDR_W-1:0] ADDR_DEMO_SOUNDS = 32'h5000_0000;
    localparam logic [ADDR_W-1:0] ADDR_ADAPTER_ENA = 32'hF200_0000;
    localparam logic [ADDR_W-1:0] ADDR_RESET       = 32'h8000_0000;
    localparam logic [ADDR_W-1:0] ADDR_ADAPTER_CFG = 32'hF700_0000;

    // dip fields
    localparam int LIVES_W      = 2;
    localparam int DIFFICULTY_W = 3;
    localparam int BONUS_W      = 3;
    localparam int DIP_W        = 16;

    //////////////////////////////////////////////////////////////////////
    // external controller adapter
    //////////////////////////////////////////////////////////////////////
    localparam int SNAC_TYPE_W = 5;
    localparam logic [SNAC_TYPE_W-1:0] SNAC_NONE     = 5'h00;
    localparam logic [SNAC_TYPE_W-1:0] SNAC_ANALOG_A = 5'h12;
    localparam logic [SNAC_TYPE_W-1:0] SNAC_ANALOG_B = 5'h13;

    localparam int ASSIGN_W = 2;
    typedef enum logic [ASSIGN_W-1:0] {
        ASSIGN_P1_P1   = 2'd0,
        ASSIGN_P1_P2   = 2'd1,
        ASSIGN_BOTH    = 2'd2,
        ASSIGN_SWAPPED = 2'd3
    } snac_assign_t;

    // config word layout, other bits read as zero
    localparam int CFG_TYPE_LSB   = 0;
    localparam int CFG_ASSIGN_LSB = 6;

    //////////////////////////////////////////////////////////////////////
    // controls
    //////////////////////////////////////////////////////////////////////
    localparam int KEY_W     = 16;
    localparam int KEY_UP    = 0;
    localparam int KEY_DOWN  = 1;
    localparam int KEY_LEFT  = 2;
    localparam int KEY_RIGHT = 3;
    localparam int KEY_FIRE  = 4;
    localparam int KEY_COIN  = 14;
    localparam int KEY_START = 15;

    // left stick, unsigned, idle near 0x80
    localparam int JOY_W       = 32;
    localparam int STICK_W     = 8;
    localparam int STICK_X_LSB = 0;
    localparam int STICK_Y_LSB = 8;
    localparam logic [STICK_W-1:0] STICK_LOW  = 8'h40;
    localparam logic [STICK_W-1:0] STICK_HIGH = 8'hC0;

    // up, down, left, right, fire, start, coin pulse
    localparam int GAME_CTRL_W = 7;

    // timing
    localparam int RESET_HOLD_CYCLES = 64;
    localparam int HOLD_CNT_W        = $clog2(RESET_HOLD_CYCLES);
    localparam int COIN_PULSE_LEN    = 16;
    localparam int COIN_CNT_W        = $clog2(COIN_PULSE_LEN);

    typedef enum logic {
        HOLD_IDLE,
        HOLD_ACTIVE
    } hold_state_t;

endpackage

// File: common/core_settings_if.sv
// decoded core settings, from the register block to their users
// regs drives everything, route and hold see only what they need

`timescale 1ns/1ns

interface core_settings_if
    import arcade_pkg::*;
();

    // dip switch fields
    logic [LIVES_W-1:0]      lives;
    logic [DIFFICULTY_W-1:0] difficulty;
    logic [BONUS_W-1:0]      bonus;
    logic                    demo_sounds;

    // external controller adapter
    logic                    adapter_ena;
    logic [SNAC_TYPE_W-1:0]  snac_type;
    snac_assign_t            snac_assign;

    // flips on every write to the reset address
    logic                    reset_flag;

    modport regs (
        output lives, difficulty, bonus, demo_sounds,
        output adapter_ena, snac_type, snac_assign,
        output reset_flag
    );

    modport route (
        input adapter_ena, snac_type, snac_assign
    );

    modport hold (
        input reset_flag
    );

endinterface

// File: design/arcade_ctrl_top.sv
// top of the game control and settings layer
// bridge registers, game reset stretcher, player 1 routing and coin pulse
// with all external connections as plain ports

`timescale 1ns/1ns

module arcade_ctrl_top
    import arcade_pkg::*;
(
    input  logic                   clk_74a,
    input  logic                   reset,
    // host bridge
    input  logic [ADDR_W-1:0]      bridge_addr,
    input  logic                   bridge_wr,
    input  logic [DATA_W-1:0]      bridge_wr_data,
    input  logic                   bridge_rd,
    output logic [DATA_W-1:0]      bridge_rd_data,
    // controllers
    input  logic [KEY_W-1:0]       cont1_key,
    input  logic [KEY_W-1:0]       snac_p1_btn,
    input  logic [KEY_W-1:0]       snac_p2_btn,
    input  logic [JOY_W-1:0]       snac_p1_joy,
    input  logic [JOY_W-1:0]       snac_p2_joy,
    // to the game
    output logic [GAME_CTRL_W-1:0] game_ctrl,
    output logic [DIP_W-1:0]       game_dips,
    output logic                   game_reset
);

    logic [KEY_W-1:0] p1_controls;
    logic             coin_pulse_out;
    logic [DIP_W-1:0] dip_word;

    core_settings_if settings_bus ();

    core_settings_regs core_settings_regs_inst (
        .clk_74a        (clk_74a),
        .reset          (reset),
        .bridge_addr    (bridge_addr),
        .bridge_wr      (bridge_wr),
        .bridge_wr_data (bridge_wr_data),
        .bridge_rd      (bridge_rd),
        .bridge_rd_data (bridge_rd_data),
        .settings       (settings_bus.regs)
    );

    reset_stretch reset_stretch_inst (
        .clk_74a    (clk_74a),
        .reset      (reset),
        .settings   (settings_bus.hold),
        .game_reset (game_reset)
    );

    input_route input_route_inst (
        .clk_74a     (clk_74a),
        .reset       (reset),
        .settings    (settings_bus.route),
        .cont1_key   (cont1_key),
        .snac_p1_btn (snac_p1_btn),
        .snac_p2_btn (snac_p2_btn),
        .snac_p1_joy (snac_p1_joy),
        .snac_p2_joy (snac_p2_joy),
        .p1_controls (p1_controls)
    );

    coin_pulse coin_pulse_inst (
        .clk_74a (clk_74a),
        .reset   (reset),
        .coin    (p1_controls[KEY_COIN]),
        .pulse   (coin_pulse_out)
    );

    //////////////////////////////////////////////////////////////////////
    // game side packing
    //////////////////////////////////////////////////////////////////////
    // game order, six unused bits between lives and difficulty
    assign dip_word = {settings_bus.demo_sounds, 1'b0, settings_bus.lives, 6'b0,
                       settings_bus.difficulty, settings_bus.bonus};

    // game expects the bytes swapped
    assign game_dips = {dip_word[DIP_W/2-1:0], dip_word[DIP_W-1:DIP_W/2]};

    assign game_ctrl = {p1_controls[KEY_UP], p1_controls[KEY_DOWN],
                        p1_controls[KEY_LEFT], p1_controls[KEY_RIGHT],
                        p1_controls[KEY_FIRE], p1_controls[KEY_START],
                        coin_pulse_out};

endmodule

// File: design/coin_pulse.sv
// turns a coin button release into a pulse of fixed length
// input is ignored while a pulse runs

`timescale 1ns/1ns

module coin_pulse
    import arcade_pkg::*;
(
    input  logic clk_74a,
    input  logic reset,
    input  logic coin,
    output logic pulse
);

    logic                  coin_prev;
    logic [COIN_CNT_W-1:0] pulse_cnt;

    always_ff @(posedge clk_74a) begin
        if (reset) begin
            coin_prev <= 1'b0;
            pulse     <= 1'b0;
            pulse_cnt <= '0;
        end else begin
            // tracked always, so a release inside a pulse is dropped
            coin_prev <= coin;
            if (pulse) begin
                if (pulse_cnt == '0) begin
                    pulse <= 1'b0;
                end else begin
                    pulse_cnt <= pulse_cnt - 1'b1;
                end
            end else if (coin_prev && !coin) begin
                // release seen
                pulse     <= 1'b1;
                pulse_cnt <= COIN_CNT_W'(COIN_PULSE_LEN - 1);
            end
        end
    end

endmodule

// File: design/core_settings_regs.sv
// host bridge register block for the core settings
// decodes single-cycle writes into settings fields and answers
// config word reads one cycle after the read strobe

`timescale 1ns/1ns

module core_settings_regs
    import arcade_pkg::*;
(
    input  logic              clk_74a,
    input  logic              reset,
    input  logic [ADDR_W-1:0] bridge_addr,
    input  logic              bridge_wr,
    input  logic [DATA_W-1:0] bridge_wr_data,
    input  logic              bridge_rd,
    output logic [DATA_W-1:0] bridge_rd_data,
    core_settings_if.regs     settings
);

    // packed config word for read back
    logic [DATA_W-1:0] cfg_word;

    always_comb begin
        cfg_word = '0;
        cfg_word[CFG_TYPE_LSB +: SNAC_TYPE_W] = settings.snac_type;
        cfg_word[CFG_ASSIGN_LSB +: ASSIGN_W]  = settings.snac_assign;
    end

    //////////////////////////////////////////////////////////////////////
    // write decode
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_74a) begin
        if (reset) begin
            settings.lives       <= '0;
            settings.difficulty  <= '0;
            settings.bonus       <= '0;
            settings.demo_sounds <= 1'b0;
            settings.adapter_ena <= 1'b0;
            settings.snac_type   <= SNAC_NONE;
            settings.snac_assign <= ASSIGN_P1_P1;
            settings.reset_flag  <= 1'b0;
        end else if (bridge_wr) begin
            // exact match only, unknown addresses fall through
            case (bridge_addr)
                ADDR_LIVES:       settings.lives       <= bridge_wr_data[LIVES_W-1:0];
                ADDR_DIFFICULTY:  settings.difficulty  <= bridge_wr_data[DIFFICULTY_W-1:0];
                ADDR_BONUS:       settings.bonus       <= bridge_wr_data[BONUS_W-1:0];
                ADDR_DEMO_SOUNDS: settings.demo_sounds <= bridge_wr_data[0];
                ADDR_ADAPTER_ENA: settings.adapter_ena <= bridge_wr_data[0];
                ADDR_ADAPTER_CFG: begin
                    settings.snac_type <= bridge_wr_data[CFG_TYPE_LSB +: SNAC_TYPE_W];
                    settings.snac_assign <=
                        snac_assign_t'(bridge_wr_data[CFG_ASSIGN_LSB +: ASSIGN_W]);
                end
                // data ignored, the write itself is the event
                ADDR_RESET:       settings.reset_flag  <= ~settings.reset_flag;
                default: ;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // read back
    //////////////////////////////////////////////////////////////////////
    // holds until the next read strobe
    always_ff @(posedge clk_74a) begin
        if (reset) begin
            bridge_rd_data <= '0;
        end else if (bridge_rd) begin
            if (bridge_addr == ADDR_ADAPTER_CFG) begin
                bridge_rd_data <= cfg_word;
            end else begin
                bridge_rd_data <= '0;
            end
        end
    end

endmodule

// File: design/reset_stretch.sv
// stretches each reset flag toggle into a game reset of fixed length
// toggles inside a hold are absorbed, system reset is ORed in

`timescale 1ns/1ns

module reset_stretch
    import arcade_pkg::*;
(
    input  logic          clk_74a,
    input  logic          reset,
    core_settings_if.hold settings,
    output logic          game_reset
);

    logic                  flag_prev;
    hold_state_t           state;
    logic [HOLD_CNT_W-1:0] hold_cnt;

    always_ff @(posedge clk_74a) begin
        if (reset) begin
            flag_prev <= 1'b0;
            state     <= HOLD_IDLE;
            hold_cnt  <= '0;
        end else begin
            // follow the level every cycle so a toggle never fires late
            flag_prev <= settings.reset_flag;
            case (state)
                HOLD_IDLE: begin
                    if (settings.reset_flag != flag_prev) begin
                        state    <= HOLD_ACTIVE;
                        hold_cnt <= HOLD_CNT_W'(RESET_HOLD_CYCLES - 1);
                    end
                end
                HOLD_ACTIVE: begin
                    if (hold_cnt == '0) begin
                        state <= HOLD_IDLE;
                    end else begin
                        hold_cnt <= hold_cnt - 1'b1;
                    end
                end
                default: state <= HOLD_IDLE;
            endcase
        end
    end

    assign game_reset = reset | (state == HOLD_ACTIVE);

endmodule

// File: input_route/input_route.sv
// player 1 control source select
// picks the handheld pad or an external adapter pad from the adapter
// settings, reduces analog sticks to a digital pad, registers the result

`timescale 1ns/1ns

module input_route
    import arcade_pkg::*;
(
    input  logic             clk_74a,
    input  logic             reset,
    core_settings_if.route   settings,
    input  logic [KEY_W-1:0] cont1_key,
    input  logic [KEY_W-1:0] snac_p1_btn,
    input  logic [KEY_W-1:0] snac_p2_btn,
    input  logic [JOY_W-1:0] snac_p1_joy,
    input  logic [JOY_W-1:0] snac_p2_joy,
    output logic [KEY_W-1:0] p1_controls
);

    logic             is_analog;
    logic             use_adapter;
    logic [KEY_W-1:0] ext_p1;
    logic [KEY_W-1:0] ext_p2;
    logic [KEY_W-1:0] next_controls;

    // overrides the dpad bits with stick tests on analog pads
    function automatic logic [KEY_W-1:0] apply_stick(
        input logic [KEY_W-1:0] btn,
        input logic [JOY_W-1:0] joy,
        input logic             analog
    );
        logic [STICK_W-1:0] stick_x;
        logic [STICK_W-1:0] stick_y;
        logic [KEY_W-1:0]   keys;
        stick_x = joy[STICK_X_LSB +: STICK_W];
        stick_y = joy[STICK_Y_LSB +: STICK_W];
        keys    = btn;
        if (analog) begin
            // low y is up, low x is left
            keys[KEY_UP]    = (stick_y < STICK_LOW);
            keys[KEY_DOWN]  = (stick_y > STICK_HIGH);
            keys[KEY_LEFT]  = (stick_x < STICK_LOW);
            keys[KEY_RIGHT] = (stick_x > STICK_HIGH);
        end
        return keys;
    endfunction

    assign is_analog = (settings.snac_type == SNAC_ANALOG_A) ||
                       (settings.snac_type == SNAC_ANALOG_B);

    // type none behaves like a disabled adapter
    assign use_adapter = settings.adapter_ena && (settings.snac_type != SNAC_NONE);

    assign ext_p1 = apply_stick(snac_p1_btn, snac_p1_joy, is_analog);
    assign ext_p2 = apply_stick(snac_p2_btn, snac_p2_joy, is_analog);

    //////////////////////////////////////////////////////////////////////
    // source select
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        next_controls = cont1_key;
        if (use_adapter) begin
            case (settings.snac_assign)
                ASSIGN_P1_P1,
                ASSIGN_BOTH:    next_controls = ext_p1;
                // external pad goes to player 2, p1 stays on the handheld
                ASSIGN_P1_P2:   next_controls = cont1_key;
                ASSIGN_SWAPPED: next_controls = ext_p2;
                default:        next_controls = cont1_key;
            endcase
        end
    end

    // one cycle latency from inputs and settings
    always_ff @(posedge clk_74a) begin
        if (reset) begin
            p1_controls <= '0;
        end else begin
            p1_controls <= next_controls;
        end
    end

endmodule

// File: src.f
common/arcade_pkg.sv
common/core_settings_if.sv
design/core_settings_regs.sv
design/reset_stretch.sv
input_route/input_route.sv
design/coin_pulse.sv
design/arcade_ctrl_top.sv
testbench/arcade_ctrl_props.sv
testbench/arcade_ctrl_tb.sv

// File: testbench/arcade_ctrl_props.sv
// bound checks on the arcade control top level
// reset coverage of the game reset, coin pulse width, read data of other addresses

`timescale 1ns/1ns

module arcade_ctrl_props
    import arcade_pkg::*;
(
    input logic                   clk_74a,
    input logic                   reset,
    input logic [ADDR_W-1:0]      bridge_addr,
    input logic                   bridge_rd,
    input logic [DATA_W-1:0]      bridge_rd_data,
    input logic [GAME_CTRL_W-1:0] game_ctrl,
    input logic                   game_reset
);

    // system reset always reaches the game
    // and the stretcher comes out of it idle
    game_reset_in_reset: assert property (@(posedge clk_74a)
        reset |-> game_reset ##1 (reset || !game_reset))
        else $error("game_reset wrong during or right after system reset");

    // coin pulse is the lsb of game_ctrl
    coin_pulse_width: assert property (@(posedge clk_74a) disable iff (reset)
        $rose(game_ctrl[0]) |-> game_ctrl[0] [*COIN_PULSE_LEN] ##1 !game_ctrl[0])
        else $error("coin pulse width differs from COIN_PULSE_LEN");

    // only the config address returns data
    other_read_zero: assert property (@(posedge clk_74a) disable iff (reset)
        (bridge_rd && bridge_addr != ADDR_ADAPTER_CFG) |=> bridge_rd_data == '0)
        else $error("nonzero read data for an address other than the config word");

endmodule

bind arcade_ctrl_top arcade_ctrl_props arcade_ctrl_props_inst (
    .clk_74a        (clk_74a),
    .reset          (reset),
    .bridge_addr    (bridge_addr),
    .bridge_rd      (bridge_rd),
    .bridge_rd_data (bridge_rd_data),
    .game_ctrl      (game_ctrl),
    .game_reset     (game_reset)
);

// File: testbench/arcade_ctrl_tb.sv
// testbench for the arcade control top level
// bridge writes and reads, player 1 routing, coin pulse and game reset hold
// expected values come from a settings model kept alongside the bridge traffic

`timescale 1ns/1ns

module arcade_ctrl_tb
    import arcade_pkg::*;
();

    localparam int CLK_PERIOD = 10;
    // rough cycle counts per test, reset first
    localparam int RUN_CYCLES = 6 + 32 + 20 + 52 + 136 + 64 + 74;

    logic                   clk_74a;
    logic                   reset;
    logic [ADDR_W-1:0]      bridge_addr;
    logic                   bridge_wr;
    logic [DATA_W-1:0]      bridge_wr_data;
    logic                   bridge_rd;
    logic [DATA_W-1:0]      bridge_rd_data;
    logic [KEY_W-1:0]       cont1_key;
    logic [KEY_W-1:0]       snac_p1_btn;
    logic [KEY_W-1:0]       snac_p2_btn;
    logic [JOY_W-1:0]       snac_p1_joy;
    logic [JOY_W-1:0]       snac_p2_joy;
    logic [GAME_CTRL_W-1:0] game_ctrl;
    logic [DIP_W-1:0]       game_dips;
    logic                   game_reset;

    // settings model, follows every bridge write
    logic [LIVES_W-1:0]      m_lives;
    logic [DIFFICULTY_W-1:0] m_difficulty;
    logic [BONUS_W-1:0]      m_bonus;
    logic                    m_demo;
    logic                    m_ena;
    logic [SNAC_TYPE_W-1:0]  m_type;
    snac_assign_t            m_assign;

    integer                 seed = 32'hadf2;
    logic                   ctrl_check_en;
    logic [GAME_CTRL_W-1:0] exp_ctrl;
    logic [DATA_W-1:0]      wdata;
    int                     wait_cnt;
    int                     high_cnt;

    arcade_ctrl_top arcade_ctrl_top_inst (
        .clk_74a        (clk_74a),
        .reset          (reset),
        .bridge_addr    (bridge_addr),
        .bridge_wr      (bridge_wr),
        .bridge_wr_data (bridge_wr_data),
        .bridge_rd      (bridge_rd),
        .bridge_rd_data (bridge_rd_data),
        .cont1_key      (cont1_key),
        .snac_p1_btn    (snac_p1_btn),
        .snac_p2_btn    (snac_p2_btn),
        .snac_p1_joy    (snac_p1_joy),
        .snac_p2_joy    (snac_p2_joy),
        .game_ctrl      (game_ctrl),
        .game_dips      (game_dips),
        .game_reset     (game_reset)
    );

    initial clk_74a = 1'b0;
    always #(CLK_PERIOD / 2) clk_74a = ~clk_74a;

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////
    // game order word, then bytes swapped
    function automatic logic [DIP_W-1:0] ref_dips();
        logic [DIP_W-1:0] word;
        word = {m_demo, 1'b0, m_lives, 6'b0, m_difficulty, m_bonus};
        return {word[7:0], word[15:8]};
    endfunction

    // p1 source from the model and the pads, coin bit left at zero
    function automatic logic [GAME_CTRL_W-1:0] ref_controls();
        logic [KEY_W-1:0] src;
        logic [JOY_W-1:0] joy;
        logic             analog;
        src    = cont1_key;
        joy    = snac_p1_joy;
        analog = (m_type == SNAC_ANALOG_A) || (m_type == SNAC_ANALOG_B);
        if (m_ena && m_type != SNAC_NONE && m_assign != ASSIGN_P1_P2) begin
            src = snac_p1_btn;
            if (m_assign == ASSIGN_SWAPPED) begin
                src = snac_p2_btn;
                joy = snac_p2_joy;
            end
            if (analog) begin
                // y in bits 15..8, x in bits 7..0
                src[KEY_UP]    = joy[15:8] < 8'h40;
                src[KEY_DOWN]  = joy[15:8] > 8'hC0;
                src[KEY_LEFT]  = joy[7:0] < 8'h40;
                src[KEY_RIGHT] = joy[7:0] > 8'hC0;
            end
        end
        return {src[KEY_UP], src[KEY_DOWN], src[KEY_LEFT], src[KEY_RIGHT],
                src[KEY_FIRE], src[KEY_START], 1'b0};
    endfunction

    //////////////////////////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////////////////////////
    task automatic stop_run();
        $display("TEST FAILED");
        $fatal(1, "stopped at first error");
    endtask

    // coin bit masked
    task automatic check_ctrl(input logic [GAME_CTRL_W-1:0] exp,
                              input logic [GAME_CTRL_W-1:0] got);
        if (got[GAME_CTRL_W-1:1] !== exp[GAME_CTRL_W-1:1]) begin
            $display("ERR %0t: game_ctrl expected %b got %b", $time, exp, got);
            stop_run();
        end
    endtask

    task automatic check_dips(input logic [DIP_W-1:0] exp, input logic [DIP_W-1:0] got);
        if (got !== exp) begin
            $display("ERR %0t: game_dips expected %h got %h", $time, exp, got);
            stop_run();
        end
    endtask

    task automatic check_word(input logic [DATA_W-1:0] exp, input logic [DATA_W-1:0] got);
        if (got !== exp) begin
            $display("ERR %0t: bridge_rd_data expected %h got %h", $time, exp, got);
            stop_run();
        end
    endtask

    task automatic check_reset(input logic exp, input logic got);
        if (got !== exp) begin
            $display("ERR %0t: game_reset expected %b got %b", $time, exp, got);
            stop_run();
        end
    endtask

    task automatic check_count(input string what, input int exp, input int got);
        if (got != exp) begin
            $display("ERR %0t: %s expected %0d got %0d", $time, what, exp, got);
            stop_run();
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus helpers
    //////////////////////////////////////////////////////////////////////
    // inputs change 1 ns after the edge
    task automatic step_clock();
        @(posedge clk_74a);
        #1;
    endtask

    // model follows after the edge, the DUT sees the write at that edge
    task automatic write_reg(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        bridge_addr    = addr;
        bridge_wr_data = data;
        bridge_wr      = 1'b1;
        step_clock();
        bridge_wr = 1'b0;
        case (addr)
            ADDR_LIVES:       m_lives      = data[LIVES_W-1:0];
            ADDR_DIFFICULTY:  m_difficulty = data[DIFFICULTY_W-1:0];
            ADDR_BONUS:       m_bonus      = data[BONUS_W-1:0];
            ADDR_DEMO_SOUNDS: m_demo       = data[0];
            ADDR_ADAPTER_ENA: m_ena        = data[0];
            ADDR_ADAPTER_CFG: begin
                m_type   = data[4:0];
                m_assign = snac_assign_t'(data[7:6]);
            end
            default: ;
        endcase
    endtask

    task automatic read_reg(input logic [ADDR_W-1:0] addr);
        bridge_addr = addr;
        bridge_rd   = 1'b1;
        step_clock();
        bridge_rd = 1'b0;
    endtask

    task automatic drive_random_pads();
        cont1_key   = $random(seed);
        snac_p1_btn = $random(seed);
        snac_p2_btn = $random(seed);
        snac_p1_joy = $random(seed);
        snac_p2_joy = $random(seed);
        step_clock();
    endtask

    // control compare, expected taken from the inputs at the edge
    always @(posedge clk_74a) begin
        if (ctrl_check_en) begin
            exp_ctrl = ref_controls();
            #2;
            check_ctrl(exp_ctrl, game_ctrl);
        end
    end

    // watchdog
    initial begin
        #((RUN_CYCLES + 100) * CLK_PERIOD);
        $display("timeout, the tests did not finish in the expected time");
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////
    initial begin
        reset          = 1'b1;
        bridge_addr    = '0;
        bridge_wr      = 1'b0;
        bridge_wr_data = '0;
        bridge_rd      = 1'b0;
        cont1_key      = '0;
        snac_p1_btn    = '0;
        snac_p2_btn    = '0;
        snac_p1_joy    = '0;
        snac_p2_joy    = '0;
        ctrl_check_en  = 1'b0;
        m_lives        = '0;
        m_difficulty   = '0;
        m_bonus        = '0;
        m_demo         = 1'b0;
        m_ena          = 1'b0;
        m_type         = SNAC_NONE;
        m_assign       = ASSIGN_P1_P1;

        repeat (4) begin
            step_clock();
            check_reset(1'b1, game_reset);
        end
        reset = 1'b0;
        step_clock();
        check_reset(1'b0, game_reset);
        check_dips(16'h0000, game_dips);
        check_word(32'h0, bridge_rd_data);

        // 1. dip fields, then unknown addresses
        repeat (24) begin
            wdata = $random(seed);
            case (wdata[9:8])
                2'd0: write_reg(ADDR_LIVES, $random(seed));
                2'd1: write_reg(ADDR_DIFFICULTY, $random(seed));
                2'd2: write_reg(ADDR_BONUS, $random(seed));
                default: write_reg(ADDR_DEMO_SOUNDS, $random(seed));
            endcase
            check_dips(ref_dips(), game_dips);
        end
        write_reg(32'h2000_0001, $random(seed));
        check_dips(ref_dips(), game_dips);
        write_reg(32'h6000_0000, $random(seed));
        check_dips(ref_dips(), game_dips);
        write_reg(32'hF700_0004, $random(seed));
        check_dips(ref_dips(), game_dips);
        // config word untouched by the near miss
        read_reg(ADDR_ADAPTER_CFG);
        check_word({24'h0, m_assign, 1'b0, m_type}, bridge_rd_data);

        // 2. config read back, other reads give zero
        repeat (4) begin
            wdata = $random(seed);
            write_reg(ADDR_ADAPTER_CFG, wdata);
            read_reg(ADDR_ADAPTER_CFG);
            check_word({24'h0, wdata[7:6], 1'b0, wdata[4:0]}, bridge_rd_data);
            // held until the next read
            step_clock();
            check_word({24'h0, wdata[7:6], 1'b0, wdata[4:0]}, bridge_rd_data);
            read_reg(ADDR_LIVES);
            check_word(32'h0, bridge_rd_data);
        end

        // 3. handheld pad with adapter off, then on with type none
        write_reg(ADDR_ADAPTER_ENA, 32'h0);
        ctrl_check_en = 1'b1;
        repeat (24) drive_random_pads();
        write_reg(ADDR_ADAPTER_CFG, {24'h0, 2'd3, 1'b0, SNAC_NONE});
        write_reg(ADDR_ADAPTER_ENA, 32'h1);
        repeat (24) drive_random_pads();

        // 4. every assignment, digital type then analog sticks
        for (int a = 0; a < 4; a++) begin
            write_reg(ADDR_ADAPTER_CFG, {24'h0, a[1:0], 1'b0, 5'h01});
            repeat (16) drive_random_pads();
        end
        for (int a = 0; a < 4; a++) begin
            write_reg(ADDR_ADAPTER_CFG, {24'h0, a[1:0], 1'b0, SNAC_ANALOG_A});
            repeat (16) drive_random_pads();
        end
        ctrl_check_en = 1'b0;

        // 5. coin pulse, let any pulse from random pads die out first
        write_reg(ADDR_ADAPTER_ENA, 32'h0);
        cont1_key   = '0;
        snac_p1_btn = '0;
        snac_p2_btn = '0;
        repeat (COIN_PULSE_LEN + 4) step_clock();
        cont1_key[KEY_COIN] = 1'b1;
        repeat (3) step_clock();
        cont1_key[KEY_COIN] = 1'b0;
        wait_cnt = 0;
        while (game_ctrl[0] !== 1'b1 && wait_cnt < 3) begin
            step_clock();
            wait_cnt++;
        end
        if (game_ctrl[0] !== 1'b1) begin
            $display("coin pulse did not start within 3 cycles of the release");
            stop_run();
        end
        high_cnt = 0;
        while (game_ctrl[0] === 1'b1 && high_cnt < 2 * COIN_PULSE_LEN) begin
            high_cnt++;
            // second press and release inside the pulse
            if (high_cnt == 4) cont1_key[KEY_COIN] = 1'b1;
            if (high_cnt == 8) cont1_key[KEY_COIN] = 1'b0;
            step_clock();
        end
        check_count("coin pulse length", COIN_PULSE_LEN, high_cnt);
        repeat (COIN_PULSE_LEN) begin
            if (game_ctrl[0] !== 1'b0) begin
                $display("coin pulse fired again after a release inside the pulse");
                stop_run();
            end
            step_clock();
        end

        // 6. game reset hold, second toggle inside the hold
        write_reg(ADDR_RESET, 32'h0);
        check_reset(1'b0, game_reset);
        step_clock();
        for (int i = 0; i < RESET_HOLD_CYCLES; i++) begin
            check_reset(1'b1, game_reset);
            bridge_addr = ADDR_RESET;
            bridge_wr   = (i == 10);
            step_clock();
        end
        repeat (8) begin
            check_reset(1'b0, game_reset);
            step_clock();
        end

        $display("TEST PASSED");
        $finish;
    end

endmodule
